// ==== rtl/eeprom_pkg.sv ====
package eeprom_pkg;

    localparam int ADDR_W      = 11;
    localparam int CMD_CREDITS = 2;     // equals queue depth
    localparam int DIV_W       = 8;

    localparam logic [DIV_W-1:0] DIV_RESET      = DIV_W'(4);
    localparam logic [3:0]       DEV_CODE_RESET = 4'b1010;

    localparam logic CFG_DIV = 1'b0;
    localparam logic CFG_DEV = 1'b1;

    // one-hot bit positions of the sequencer
    localparam int S_IDLE     = 0;
    localparam int S_START    = 1;
    localparam int S_CTRL_WR  = 2;
    localparam int S_ADDR     = 3;
    localparam int S_DATA_WR  = 4;
    localparam int S_RESTART  = 5;
    localparam int S_CTRL_RD  = 6;
    localparam int S_DATA_RD  = 7;
    localparam int S_STOP     = 8;
    localparam int S_DONE     = 9;
    localparam int SEQ_STATES = 10;

    localparam int COND_LAST = 2;       // last half-period of START/STOP
    localparam int BYTE_LAST = 17;      // 8 data bits + ack

    typedef enum logic [1:0] {
        OP_START,                       // also repeated START
        OP_STOP,
        OP_WRITE,
        OP_READ
    } bit_op_t;

    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [3:0] dev_code;
            logic [2:0] block;          // address bits 10..8
            logic       rw;
        } f;
    } ctrl_byte_u;

endpackage

// ==== rtl/eeprom_cfg_regs.sv ====
`timescale 1ns/10ps
module eeprom_cfg_regs (
    input  logic                         CLK,
    input  logic                         RESET,
    input  logic                         cfg_we,
    input  logic                         cfg_addr,
    input  logic [7:0]                   cfg_wdata,
    output logic [7:0]                   cfg_rdata,
    output logic [eeprom_pkg::DIV_W-1:0] clk_div,
    output logic [3:0]                   dev_code
);
    import eeprom_pkg::*;

    logic zero_div_wr;

    assign zero_div_wr = cfg_we && (cfg_addr == CFG_DIV) && (cfg_wdata == 8'd0);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            clk_div  <= DIV_RESET;
            dev_code <= DEV_CODE_RESET;
        end
        else if (cfg_we)
        begin
            if (cfg_addr == CFG_DIV && !zero_div_wr)
                clk_div <= cfg_wdata[DIV_W-1:0];
            else if (cfg_addr == CFG_DEV)
                dev_code <= cfg_wdata[3:0];   // upper nibble dropped
        end
    end

    assign cfg_rdata = (cfg_addr == CFG_DIV) ? 8'(clk_div) : {4'b0000, dev_code};

    // zero divider would stall SCL, write is dropped
    a_zero_div: assert property (@(posedge CLK) disable iff (RESET) !zero_div_wr)
        else $warning("divider write of zero ignored, keeping %0d", clk_div);

endmodule

// ==== rtl/eeprom_cmd_queue.sv ====
`timescale 1ns/10ps
module eeprom_cmd_queue (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          cmd_valid,
    input  logic                          cmd_write,
    input  logic [eeprom_pkg::ADDR_W-1:0] cmd_addr,
    input  logic [7:0]                    cmd_wdata,
    output logic                          q_valid,
    output logic                          q_write,
    output logic [eeprom_pkg::ADDR_W-1:0] q_addr,
    output logic [7:0]                    q_wdata,
    input  logic                          q_pop,
    output logic                          cmd_credit
);
    import eeprom_pkg::*;

    logic              write_mem [CMD_CREDITS];
    logic [ADDR_W-1:0] addr_mem  [CMD_CREDITS];
    logic [7:0]        wdata_mem [CMD_CREDITS];
    logic              wr_ptr;
    logic              rd_ptr;
    logic [1:0]        count;

    always_ff @(posedge CLK)
    begin
        if (cmd_valid)
        begin
            write_mem[wr_ptr] <= cmd_write;
            addr_mem[wr_ptr]  <= cmd_addr;
            wdata_mem[wr_ptr] <= cmd_wdata;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr     <= 1'b0;
            rd_ptr     <= 1'b0;
            count      <= 2'd0;
            cmd_credit <= 1'b0;
        end
        else
        begin
            wr_ptr     <= wr_ptr ^ cmd_valid;
            rd_ptr     <= rd_ptr ^ q_pop;
            count      <= count + 2'(cmd_valid) - 2'(q_pop);
            cmd_credit <= q_pop;   // one credit back per released entry
        end
    end

    assign q_valid = (count != 2'd0);
    assign q_write = write_mem[rd_ptr];
    assign q_addr  = addr_mem[rd_ptr];
    assign q_wdata = wdata_mem[rd_ptr];

    // host pushed without holding a credit
    a_no_overflow: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> (count != 2'(CMD_CREDITS)));

endmodule

// ==== rtl/eeprom_sequencer.sv ====
`timescale 1ns/10ps
module eeprom_sequencer (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          q_valid,
    input  logic                          q_write,
    input  logic [eeprom_pkg::ADDR_W-1:0] q_addr,
    input  logic [7:0]                    q_wdata,
    output logic                          q_pop,
    input  logic [3:0]                    dev_code,
    output logic                          op_valid,
    output eeprom_pkg::bit_op_t           op,
    output logic [7:0]                    tx_byte,
    output logic                          rx_nack,
    input  logic                          op_done,
    input  logic [7:0]                    rx_byte,
    input  logic                          ack_seen,
    output logic                          rsp_valid,
    output logic [7:0]                    rsp_rdata,
    output logic                          rsp_err
);
    import eeprom_pkg::*;

    logic [SEQ_STATES-1:0] state;
    logic                  cmd_write_r;
    logic [ADDR_W-1:0]     cmd_addr_r;
    logic [7:0]            cmd_wdata_r;
    logic [7:0]            rdata_r;
    logic                  err_r;
    logic                  pending;     // op issued, waiting for op_done
    logic                  op_state;
    ctrl_byte_u            ctrl;

    function automatic logic [SEQ_STATES-1:0] st(input int idx);
        st = '0;
        st[idx] = 1'b1;
    endfunction

    assign op_state  = !state[S_IDLE] && !state[S_DONE];
    assign q_pop     = state[S_IDLE] && q_valid;
    assign rx_nack   = state[S_DATA_RD];      // single byte read, always nack
    assign rsp_valid = state[S_DONE];
    assign rsp_rdata = rdata_r;
    assign rsp_err   = err_r;

    always_comb
    begin
        ctrl.f.dev_code = dev_code;
        ctrl.f.block    = cmd_addr_r[ADDR_W-1:8];
        ctrl.f.rw       = state[S_CTRL_RD];
        op      = OP_WRITE;
        tx_byte = ctrl.raw;
        if (state[S_START] || state[S_RESTART])
            op = OP_START;
        else if (state[S_STOP])
            op = OP_STOP;
        else if (state[S_DATA_RD])
            op = OP_READ;
        if (state[S_ADDR])
            tx_byte = cmd_addr_r[7:0];
        else if (state[S_DATA_WR])
            tx_byte = cmd_wdata_r;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= st(S_IDLE);
            pending  <= 1'b0;
            op_valid <= 1'b0;
            err_r    <= 1'b0;
        end
        else
        begin
            op_valid <= op_state && !pending;
            if (op_state && !pending)
                pending <= 1'b1;
            else if (op_done)
                pending <= 1'b0;

            if (state[S_IDLE])
                err_r <= 1'b0;
            else if (op_done && op == OP_WRITE && !ack_seen)
                err_r <= 1'b1;   // held until the response

            case (1'b1)
                state[S_IDLE]:    if (q_valid) state <= st(S_START);
                state[S_START]:   if (op_done) state <= st(S_CTRL_WR);
                state[S_CTRL_WR]: if (op_done) state <= st(ack_seen ? S_ADDR : S_STOP);
                state[S_ADDR]:
                    if (op_done)
                        state <= st(!ack_seen ? S_STOP : (cmd_write_r ? S_DATA_WR : S_RESTART));
                state[S_DATA_WR]: if (op_done) state <= st(S_STOP);
                state[S_RESTART]: if (op_done) state <= st(S_CTRL_RD);
                state[S_CTRL_RD]: if (op_done) state <= st(ack_seen ? S_DATA_RD : S_STOP);
                state[S_DATA_RD]: if (op_done) state <= st(S_STOP);
                state[S_STOP]:    if (op_done) state <= st(S_DONE);
                state[S_DONE]:    state <= st(S_IDLE);
                default:          state <= st(S_IDLE);
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (q_pop)
        begin
            cmd_write_r <= q_write;
            cmd_addr_r  <= q_addr;
            cmd_wdata_r <= q_wdata;
            rdata_r     <= 8'd0;   // writes answer with zero
        end
        else if (state[S_DATA_RD] && op_done)
            rdata_r <= rx_byte;
    end

    a_op_handshake: assert property (@(posedge CLK) disable iff (RESET)
        !(op_valid && op_done));

endmodule

// ==== rtl/eeprom_bit_engine.sv ====
`timescale 1ns/10ps
module eeprom_bit_engine (
    input  logic                         CLK,
    input  logic                         RESET,
    input  logic [eeprom_pkg::DIV_W-1:0] clk_div,
    input  logic                         op_valid,
    input  eeprom_pkg::bit_op_t          op,
    input  logic [7:0]                   tx_byte,
    input  logic                         rx_nack,
    output logic                         op_done,
    output logic [7:0]                   rx_byte,
    output logic                         ack_seen,
    output logic                         scl,
    inout  wire                          sda
);
    import eeprom_pkg::*;

    bit_op_t          op_r;
    logic             nack_r;
    logic             busy;
    logic [DIV_W-1:0] hp_cnt;        // CLK cycles within a half-period
    logic [4:0]       ph;            // half-period index within the op
    logic [4:0]       ph_next;
    logic [4:0]       ph_last;
    logic             is_byte;
    logic             tick;
    logic [7:0]       shreg;
    logic             sda_low;
    logic             sda_low_next;

    assign sda     = sda_low ? 1'b0 : 1'bz;   // open drain
    assign rx_byte = shreg;
    assign is_byte = (op_r == OP_WRITE) || (op_r == OP_READ);
    assign ph_next = ph + 5'd1;
    assign ph_last = is_byte ? 5'(BYTE_LAST) : 5'(COND_LAST);
    assign tick    = busy && (hp_cnt == clk_div - 1'b1);

    always_comb
    begin
        sda_low_next = 1'b0;
        if (op_r == OP_START)
            sda_low_next = (ph == 5'(COND_LAST));   // falls while SCL high
        else if (op_r == OP_STOP)
            sda_low_next = (ph != 5'(COND_LAST));   // rises while SCL high
        else if (ph[4:1] != 4'd8)
            sda_low_next = (op_r == OP_WRITE) && !shreg[7];
        else
            sda_low_next = (op_r == OP_READ) && !nack_r;   // our ack bit
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            op_done <= 1'b0;
            scl     <= 1'b1;
            sda_low <= 1'b0;
            hp_cnt  <= '0;
            ph      <= 5'd0;
        end
        else
        begin
            op_done <= 1'b0;
            if (op_valid && !busy)
            begin
                busy   <= 1'b1;
                hp_cnt <= '0;
                ph     <= 5'd0;
                scl    <= 1'b0;   // every op opens with SCL low
            end
            else if (busy)
            begin
                // data moves one CLK after the SCL edge
                if (hp_cnt == '0)
                    sda_low <= sda_low_next;
                if (tick)
                begin
                    hp_cnt <= '0;
                    if (ph == ph_last)
                    begin
                        busy    <= 1'b0;
                        op_done <= 1'b1;
                    end
                    else
                    begin
                        ph  <= ph_next;
                        scl <= is_byte ? ph_next[0] : 1'b1;
                    end
                end
                else
                    hp_cnt <= hp_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (op_valid && !busy)
        begin
            op_r   <= op;
            nack_r <= rx_nack;
            shreg  <= tx_byte;
        end
        else if (tick && is_byte && ph[0])
        begin
            if (ph == 5'(BYTE_LAST))
                ack_seen <= !sda;
            else
                shreg <= {shreg[6:0], sda};   // sample at end of SCL high
        end
    end

    a_op_when_idle: assert property (@(posedge CLK) disable iff (RESET)
        op_valid |-> !busy);

endmodule

// ==== rtl/eeprom_ctrl_top.sv ====
`timescale 1ns/10ps
module eeprom_ctrl_top (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          cmd_valid,
    input  logic                          cmd_write,
    input  logic [eeprom_pkg::ADDR_W-1:0] cmd_addr,
    input  logic [7:0]                    cmd_wdata,
    output logic                          cmd_credit,
    output logic                          rsp_valid,
    output logic [7:0]                    rsp_rdata,
    output logic                          rsp_err,
    input  logic                          cfg_we,
    input  logic                          cfg_addr,
    input  logic [7:0]                    cfg_wdata,
    output logic [7:0]                    cfg_rdata,
    output logic                          scl,
    inout  wire                           sda
);
    import eeprom_pkg::*;

    logic              q_valid;
    logic              q_write;
    logic [ADDR_W-1:0] q_addr;
    logic [7:0]        q_wdata;
    logic              q_pop;
    logic [DIV_W-1:0]  clk_div;
    logic [3:0]        dev_code;
    logic              op_valid;
    bit_op_t           op;
    logic [7:0]        tx_byte;
    logic              rx_nack;
    logic              op_done;
    logic [7:0]        rx_byte;
    logic              ack_seen;

    eeprom_cmd_queue u_queue (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd_write  (cmd_write),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata),
        .q_valid    (q_valid),
        .q_write    (q_write),
        .q_addr     (q_addr),
        .q_wdata    (q_wdata),
        .q_pop      (q_pop),
        .cmd_credit (cmd_credit)
    );

    eeprom_cfg_regs u_cfg (
        .CLK       (CLK),
        .RESET     (RESET),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .clk_div   (clk_div),
        .dev_code  (dev_code)
    );

    eeprom_sequencer u_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .q_valid   (q_valid),
        .q_write   (q_write),
        .q_addr    (q_addr),
        .q_wdata   (q_wdata),
        .q_pop     (q_pop),
        .dev_code  (dev_code),
        .op_valid  (op_valid),
        .op        (op),
        .tx_byte   (tx_byte),
        .rx_nack   (rx_nack),
        .op_done   (op_done),
        .rx_byte   (rx_byte),
        .ack_seen  (ack_seen),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .rsp_err   (rsp_err)
    );

    eeprom_bit_engine u_bits (
        .CLK      (CLK),
        .RESET    (RESET),
        .clk_div  (clk_div),
        .op_valid (op_valid),
        .op       (op),
        .tx_byte  (tx_byte),
        .rx_nack  (rx_nack),
        .op_done  (op_done),
        .rx_byte  (rx_byte),
        .ack_seen (ack_seen),
        .scl      (scl),
        .sda      (sda)
    );

endmodule

// ==== testbench/eeprom_slave_model.sv ====
`timescale 1ns/10ps
module eeprom_slave_model (
    input  logic       scl,
    inout  wire        sda,
    input  logic [3:0] dev_code
);
    logic [7:0]  mem [2048];
    logic        active;
    logic        sending;       // slave shifts a data byte out
    logic        drive_low;
    logic [3:0]  bit_cnt;       // SCL rises seen in the current byte
    logic [1:0]  byte_idx;      // 0 control, 1 address, 2 data
    logic [7:0]  sh;
    logic [7:0]  tx;
    logic [10:0] ptr;
    logic [2:0]  block;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        active    = 1'b0;
        sending   = 1'b0;
        drive_low = 1'b0;
        bit_cnt   = 4'd0;
        byte_idx  = 2'd0;
        ptr       = '0;
        block     = '0;
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ {i[10:8], 5'b00000};
    end

    task take_byte();
        drive_low = 1'b1;   // ack
        if (byte_idx == 2'd0)
        begin
            if (sh[7:4] != dev_code)
            begin
                drive_low = 1'b0;
                active    = 1'b0;   // not addressed, stay off the bus
            end
            else if (sh[0])
            begin
                sending = 1'b1;
                tx      = mem[ptr];
            end
            else
            begin
                block    = sh[3:1];
                byte_idx = 2'd1;
            end
        end
        else if (byte_idx == 2'd1)
        begin
            ptr      = {block, sh};
            byte_idx = 2'd2;
        end
        else
            mem[ptr] = sh;
    endtask

    // START or repeated START
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            active    = 1'b1;
            sending   = 1'b0;
            drive_low = 1'b0;
            bit_cnt   = 4'd0;
            byte_idx  = 2'd0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
            active = 1'b0;   // STOP
    end

    always @(posedge scl)
    begin
        if (active)
        begin
            if (bit_cnt < 4'd8)
                sh = {sh[6:0], sda};
            else if (sending && sda !== 1'b0)
                active = 1'b0;   // master nack ends the read
            bit_cnt = bit_cnt + 4'd1;
        end
    end

    always @(negedge scl)
    begin
        if (active)
        begin
            if (bit_cnt == 4'd9)
                bit_cnt = 4'd0;
            if (bit_cnt != 4'd8)
                drive_low = sending && !tx[7 - bit_cnt];
            else if (sending)
                drive_low = 1'b0;   // master answers this bit
            else
                take_byte();
        end
    end

endmodule

// ==== testbench/tb_eeprom_ctrl.sv ====
`timescale 1ns/10ps
module tb_eeprom_ctrl;
    import eeprom_pkg::*;

    localparam int MAX_STEPS = 64;

    logic              CLK;
    logic              RESET;
    logic              cmd_valid;
    logic              cmd_write;
    logic [ADDR_W-1:0] cmd_addr;
    logic [7:0]        cmd_wdata;
    logic              cmd_credit;
    logic              rsp_valid;
    logic [7:0]        rsp_rdata;
    logic              rsp_err;
    logic              cfg_we;
    logic              cfg_addr;
    logic [7:0]        cfg_wdata;
    logic [7:0]        cfg_rdata;
    logic              scl;
    wire               sda;
    logic [3:0]        model_code;

    logic [11:0]       steps [MAX_STEPS*4];   // kind, addr, data, expect
    logic              exp_write [$];
    logic [7:0]        exp_data  [$];
    logic              exp_err   [$];
    logic [7:0]        cur_div;
    int                issued;
    int                returned;
    int                high_run;
    int                min_high;
    int                limit_ns;

    pullup (sda);

    eeprom_ctrl_top uut (.*);

    eeprom_slave_model u_model (
        .scl      (scl),
        .sda      (sda),
        .dev_code (model_code)
    );

    always #4 CLK = ~CLK;

    task automatic stop_on_error(input string why);
        $display("Test FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_data(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_on_error("data byte mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_on_error("flag mismatch");
        end
    endtask

    task automatic check_cfg(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_on_error("config value mismatch");
        end
    endtask

    task automatic check_bus_idle();
        check_flag("scl", scl, 1'b1);
        check_flag("sda", sda, 1'b1);
        check_flag("cmd_credit", cmd_credit, 1'b0);
        check_flag("rsp_valid", rsp_valid, 1'b0);
    endtask

    // shortest SCL high run since the last divider change
    task automatic check_scl_high();
        if (min_high < 1000)
            check_cfg("scl_high", 8'(min_high), cur_div);
    endtask

    task automatic take_response();
        logic       w;
        logic [7:0] d;
        logic       e;
        if (exp_err.size() == 0)
            stop_on_error("response arrived with no command outstanding");
        else
        begin
            w = exp_write.pop_front();
            d = exp_data.pop_front();
            e = exp_err.pop_front();
            check_flag("rsp_err", rsp_err, e);
            if (w)
                check_data("rsp_rdata", rsp_rdata, 8'h00);
            else if (!e)
                check_data("rsp_rdata", rsp_rdata, d);
        end
    endtask

    task automatic issue_command(input logic wr, input logic [11:0] a, d, e);
        while (CMD_CREDITS - issued + returned <= 0)
            @(negedge CLK);
        cmd_valid = 1'b1;
        cmd_write = wr;
        cmd_addr  = a[ADDR_W-1:0];
        cmd_wdata = d[7:0];
        exp_write.push_back(wr);
        exp_data.push_back(d[7:0]);
        exp_err.push_back(e[0]);
        issued++;
        @(negedge CLK);
        cmd_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_err.size() != 0)
            @(negedge CLK);
    endtask

    task automatic write_cfg(input logic a, input logic [7:0] d, input logic [7:0] e);
        if (a == CFG_DIV)
            check_scl_high();
        cfg_we    = 1'b1;
        cfg_addr  = a;
        cfg_wdata = d;
        @(negedge CLK);
        cfg_we = 1'b0;
        check_cfg("cfg_rdata", cfg_rdata, e);
        if (a == CFG_DIV)
        begin
            cur_div  = e;
            min_high = 1000;
        end
    endtask

    // outputs are registered, so the value seen at the edge is the settled one
    always @(posedge CLK)
    begin
        if (!RESET)
        begin
            if (cmd_credit === 1'b1)
            begin
                returned++;
                if (returned > issued)
                    stop_on_error("credit returned with no command outstanding");
            end
            if (rsp_valid === 1'b1)
                take_response();
            if (scl === 1'b1)
                high_run++;
            else
            begin
                if (high_run > 0 && high_run < min_high)
                    min_high = high_run;
                high_run = 0;
            end
        end
    end

    initial
    begin
        wait (limit_ns > 0);
        #(limit_ns);
        stop_on_error("watchdog expired, a transaction never completed");
    end

    initial
    begin
        int          k;
        int          n;
        int          max_div;
        logic [11:0] kind;
        logic [11:0] a;
        logic [11:0] d;
        logic [11:0] e;
        CLK        = 1'b0;
        RESET      = 1'b1;
        cmd_valid  = 1'b0;
        cmd_write  = 1'b0;
        cmd_addr   = '0;
        cmd_wdata  = 8'h00;
        cfg_we     = 1'b0;
        cfg_addr   = CFG_DIV;
        cfg_wdata  = 8'h00;
        model_code = DEV_CODE_RESET;
        cur_div    = DIV_RESET;
        issued     = 0;
        returned   = 0;
        high_run   = 0;
        min_high   = 1000;
        for (k = 0; k < MAX_STEPS*4; k++)
            steps[k] = 12'hfff;   // end marker
        $readmemh("testbench/eeprom_patterns.txt", steps);
        n       = 0;
        max_div = DIV_RESET;
        while (n < MAX_STEPS && steps[4*n] != 12'hfff)
        begin
            if (steps[4*n] == 12'h000 && steps[4*n+1] == 12'h000 && steps[4*n+2] > max_div)
                max_div = steps[4*n+2];
            n++;
        end
        if (n == 0)
            stop_on_error("no steps read from the pattern file");
        limit_ns = n * 60 * max_div * 16;

        @(negedge CLK);
        check_bus_idle();
        check_cfg("cfg_rdata", cfg_rdata, DIV_RESET);
        cfg_addr = CFG_DEV;
        #1;
        check_cfg("cfg_rdata", cfg_rdata, {4'b0000, DEV_CODE_RESET});
        @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        check_bus_idle();
        check_cfg("cfg_rdata", cfg_rdata, {4'b0000, DEV_CODE_RESET});

        for (k = 0; k < n; k++)
        begin
            kind = steps[4*k];
            a    = steps[4*k+1];
            d    = steps[4*k+2];
            e    = steps[4*k+3];
            case (kind)
                12'h000:
                begin
                    wait_idle();
                    write_cfg(a[0], d[7:0], e[7:0]);
                end
                12'h001:
                begin
                    wait_idle();
                    model_code = d[3:0];
                end
                12'h002: issue_command(1'b1, a, d, e);
                12'h003: issue_command(1'b0, a, d, e);
                default: stop_on_error("unknown step kind in the pattern file");
            endcase
        end
        wait_idle();
        check_scl_high();
        if (returned != issued)
            stop_on_error("credits returned do not match the commands issued");

        $display("Test OK");
        $finish;
    end

endmodule

// ==== testbench/eeprom_patterns.txt ====
// kind addr data expect, hex. kind 0 config write (expect is readback), 1 model device code
// kind 2 write command (expect is rsp_err), kind 3 read command (data is the expected byte)
2 0a5 3c 0
2 1b6 e1 0
3 0a5 3c 0
3 1b6 e1 0
0 000 02 02
2 2c7 5a 0
3 2c7 5a 0
2 3d8 96 0
3 3d8 96 0
0 000 00 02     // zero divider is dropped
0 000 05 05
2 4e9 0f 0
2 5fa f0 0
3 4e9 0f 0
3 5fa f0 0
3 5a3 03 0      // never written, fill value
0 001 f9 09
1 000 09 0
2 60b 81 0
3 60b 81 0
1 000 0a 0      // model stops answering
3 60b 00 1
2 71c 55 1
0 001 0a 0a
3 60b 81 0
3 71c fc 0
2 71c 77 0
3 71c 77 0

// ==== filelist.f ====
rtl/eeprom_pkg.sv
rtl/eeprom_cfg_regs.sv
rtl/eeprom_cmd_queue.sv
rtl/eeprom_sequencer.sv
rtl/eeprom_bit_engine.sv
rtl/eeprom_ctrl_top.sv
testbench/eeprom_slave_model.sv
testbench/tb_eeprom_ctrl.sv
